//--- flist.f
hw/vdma_pkg.sv
hw/vram_req_if.sv
hw/line_dma.sv
hw/scroll_fetch.sv
hw/tile_cache.sv
hw/vram_arbiter.sv
hw/video_dma.sv
testbench/tb_clock.sv
testbench/tb_video_dma.sv

//--- hw/line_dma.sv
`default_nettype none

module line_dma #(
    parameter int LINE_TICKS = 16
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          pxl_cen,
    input  logic          hb,
    input  logic          flip,
    input  logic [8:0]    vrender1,
    input  logic          row_en,
    input  logic [15:0]   vram_row_base,
    input  logic [15:0]   row_offset,
    input  logic [15:0]   hpos2,
    input  logic          br_obj,
    input  logic          br_pal,
    input  logic [16:0]   vram_obj_addr,
    output logic          line_start,
    output logic          scroll_go,
    output logic [15:0]   vline,
    output logic [15:0]   row_scr,
    output logic          bg_obj,
    vram_req_if.requester bus
);

    // Counter wide enough for the OBJ tick numbers
    localparam int CW = (LINE_TICKS > 16) ? $clog2(LINE_TICKS) : 4;

    logic          last_hb;
    logic          hb_edge;
    logic          active;
    logic [CW-1:0] cnt;
    logic          tick;
    logic          last_tick;
    logic          obj_phase;
    logic [15:0]   vline_next;
    logic [9:0]    row_idx;
    logic [15:0]   row_word;
    logic [15:0]   row_scr_next;

    assign hb_edge    = hb && !last_hb;
    assign vline_next = {7'd0, (vrender1 + 9'd1) ^ {1'b0, {8{flip}}}};
    assign tick       = active && bus.gnt && pxl_cen;
    assign obj_phase  = cnt >= CW'(vdma_pkg::OBJ_START);
    // A pending palette request cuts the window short
    assign last_tick  = (cnt == CW'(LINE_TICKS - 1)) ||
                        (br_pal && cnt == CW'(vdma_pkg::PAL_CUT));

    assign row_idx  = row_offset[9:0] + vline[9:0];
    assign bus.req  = active;
    // Row-scroll word first, then the sprite copier's addresses
    assign bus.addr = obj_phase ? vram_obj_addr
                                : {vram_row_base[9:1], 8'd0} + {7'd0, row_idx};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_hb      <= 1'b0;
            line_start   <= 1'b0;
            scroll_go    <= 1'b0;
            active       <= 1'b0;
            cnt          <= '0;
            bg_obj       <= 1'b0;
            row_scr      <= 16'd0;
            row_scr_next <= 16'd0;
        end else begin
            last_hb    <= hb;
            line_start <= hb_edge;
            scroll_go  <= 1'b0;
            if (hb_edge) begin
                active  <= 1'b1;
                cnt     <= '0;
                bg_obj  <= 1'b0;
                row_scr <= row_scr_next;
            end else if (tick) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(vdma_pkg::OBJ_START)) begin
                    bg_obj       <= br_obj && !br_pal;
                    row_scr_next <= {12'd0, hpos2[3:0]} + (row_en ? row_word : 16'd0);
                end
                if (cnt == CW'(vdma_pkg::OBJ_END)) begin
                    bg_obj <= 1'b0;
                end
                if (last_tick) begin
                    active    <= 1'b0;
                    bg_obj    <= 1'b0;
                    scroll_go <= !br_pal;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hb_edge) begin
            vline <= vline_next;
        end
        if (active && bus.ok && !obj_phase) begin
            row_word <= bus.data;
        end
    end

    // Sprite grant only opens from inside the line window
    assert property (@(posedge clk) disable iff (rst)
        $rose(bg_obj) |-> $past(active));

endmodule

`default_nettype wire

//--- hw/scroll_fetch.sv
`default_nettype none

module scroll_fetch (
    input  logic          clk,
    input  logic          rst,
    input  logic          pxl_cen,
    input  logic          line_start,
    input  logic          scroll_go,
    input  logic [15:0]   vline,
    input  logic [15:0]   hpos1,
    input  logic [15:0]   hpos2,
    input  logic [15:0]   hpos3,
    input  logic [15:0]   vpos1,
    input  logic [15:0]   vpos2,
    input  logic [15:0]   vpos3,
    input  logic [15:0]   vram1_base,
    input  logic [15:0]   vram2_base,
    input  logic [15:0]   vram3_base,
    output logic          wr_en,
    output logic [7:0]    wr_slot,
    output logic [15:0]   wr_data,
    output logic [2:0]    swap_mask,
    vram_req_if.requester bus
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_CHECK = 2'd1;
    localparam logic [1:0] S_FETCH = 2'd2;
    localparam logic [1:0] S_NEXT  = 2'd3;

    logic [1:0]       state;
    vdma_pkg::layer_e layer;
    logic [10:0]      hpos_sel;
    logic [15:0]      vpos_sel;
    logic [8:0]       base_sel;
    logic [10:0]      vscr;
    logic [10:0]      tile;
    logic             fetch_row;
    logic [10:0]      vn;
    logic [10:0]      hn;
    logic [7:0]       slot;
    logic [8:0]       base_hi;
    logic [11:0]      scan;
    logic             last_word;
    logic             load;
    logic             capture;
    logic             step;

    always_comb begin
        case (layer)
            vdma_pkg::SCR1: begin
                hpos_sel = hpos1[10:0];
                vpos_sel = vpos1;
                base_sel = vram1_base[9:1];
                scan     = {vn[8], hn[8:3], vn[7:3]};
            end
            vdma_pkg::SCR2: begin
                hpos_sel = hpos2[10:0];
                vpos_sel = vpos2;
                base_sel = vram2_base[9:1];
                scan     = {vn[9:8], hn[9:4], vn[7:4]};
            end
            default: begin
                hpos_sel = hpos3[10:0];
                vpos_sel = vpos3;
                base_sel = vram3_base[9:1];
                scan     = {vn[10:8], hn[10:5], vn[7:5]};
            end
        endcase
    end

    assign tile      = vdma_pkg::TILE_SIZE[layer];
    assign vscr      = vpos_sel[10:0] + vline[10:0];
    // Only a line that opens a new tile row needs fresh map words
    assign fetch_row = (vscr & (tile - 11'd1)) == 11'd0;
    assign last_word = slot == vdma_pkg::SLOT_LAST[layer];

    assign load    = !line_start && state == S_CHECK && fetch_row;
    assign capture = !line_start && state == S_FETCH && bus.ok;
    assign step    = !line_start && state == S_NEXT && pxl_cen && bus.gnt;

    assign bus.req  = state == S_FETCH || state == S_NEXT;
    // slot[0] selects the word within the tile
    assign bus.addr = {base_hi, 8'd0} + {4'd0, scan, slot[0]};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            layer     <= vdma_pkg::SCR1;
            swap_mask <= 3'd0;
            wr_en     <= 1'b0;
        end else begin
            wr_en <= capture;
            if (line_start) begin
                // Unfinished layers keep their old bank
                state     <= S_IDLE;
                swap_mask <= 3'd0;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (scroll_go) begin
                            layer <= vdma_pkg::SCR1;
                            state <= S_CHECK;
                        end
                    end
                    S_CHECK: begin
                        if (fetch_row) begin
                            state <= S_FETCH;
                        end else if (layer == vdma_pkg::SCR3) begin
                            state <= S_IDLE;
                        end else begin
                            layer <= vdma_pkg::layer_e'(layer + 2'd1);
                        end
                    end
                    S_FETCH: begin
                        if (capture) begin
                            state <= S_NEXT;
                        end
                    end
                    default: begin
                        if (step && last_word) begin
                            swap_mask[layer] <= 1'b1;
                            if (layer == vdma_pkg::SCR3) begin
                                state <= S_IDLE;
                            end else begin
                                layer <= vdma_pkg::layer_e'(layer + 2'd1);
                                state <= S_CHECK;
                            end
                        end else if (step) begin
                            state <= S_FETCH;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            vn      <= vscr;
            hn      <= vdma_pkg::HSTART[layer] + (hpos_sel & ~(tile - 11'd1));
            slot    <= vdma_pkg::SLOT_FIRST[layer];
            base_hi <= base_sel;
        end
        if (capture) begin
            wr_slot <= slot;
            wr_data <= bus.data;
        end
        if (step && !last_word) begin
            slot <= slot + 8'd1;
            // Next tile after the second word
            if (slot[0]) begin
                hn <= hn + tile;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_slot >= vdma_pkg::SLOT_FIRST[layer] &&
                  wr_slot <= vdma_pkg::SLOT_LAST[layer]);

endmodule

`default_nettype wire

//--- hw/tile_cache.sv
`default_nettype none

module tile_cache (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [7:0]  wr_slot,
    input  logic [15:0] wr_data,
    input  logic [2:0]  swap_mask,
    input  logic        line_start,
    input  logic [7:0]  tile_addr,
    output logic [15:0] tile_data
);

    // Two banks of 256 words, bank bit on top
    logic [15:0] mem [512];
    logic [2:0]  active;
    logic        wr_bank;
    logic        rd_bank;

    // Fetcher fills the idle bank while renderers read the other one
    assign wr_bank = ~active[vdma_pkg::slot_layer(wr_slot)];
    assign rd_bank = active[vdma_pkg::slot_layer(tile_addr)];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active <= 3'd0;
        end else if (line_start) begin
            active <= active ^ swap_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_bank, wr_slot}] <= wr_data;
        end
        tile_data <= mem[{rd_bank, tile_addr}];
    end

endmodule

`default_nettype wire

//--- hw/vdma_pkg.sv
`default_nettype none

package vdma_pkg;

    // Scroll layers in fetch order
    typedef enum logic [1:0] {
        SCR1,
        SCR2,
        SCR3
    } layer_e;

    // Cache slot window of each layer, one slot per tile-map word
    localparam logic [7:0] SLOT_FIRST [3] = '{8'd0, 8'd128, 8'd226};
    localparam logic [7:0] SLOT_LAST  [3] = '{8'd99, 8'd225, 8'd255};

    // Layer geometry
    localparam logic [10:0] HSTART    [3] = '{11'h38, 11'h30, 11'h20};
    localparam logic [10:0] TILE_SIZE [3] = '{11'd8, 11'd16, 11'd32};

    // Line window tick numbers
    localparam logic [3:0] OBJ_START = 4'd3;
    localparam logic [3:0] OBJ_END   = 4'd11;
    localparam logic [3:0] PAL_CUT   = 4'd6;

    // Owning layer of a cache slot
    function automatic layer_e slot_layer(input logic [7:0] slot);
        if (slot < SLOT_FIRST[SCR2]) begin
            return SCR1;
        end
        if (slot <= SLOT_LAST[SCR2]) begin
            return SCR2;
        end
        return SCR3;
    endfunction

endpackage

`default_nettype wire

//--- hw/video_dma.sv
`default_nettype none

module video_dma #(
    parameter int LINE_TICKS = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        hb,
    input  logic [8:0]  vrender1,
    input  logic        flip,
    input  logic [15:0] vram1_base,
    input  logic [15:0] hpos1,
    input  logic [15:0] vpos1,
    input  logic [15:0] vram2_base,
    input  logic [15:0] hpos2,
    input  logic [15:0] vpos2,
    input  logic [15:0] vram3_base,
    input  logic [15:0] hpos3,
    input  logic [15:0] vpos3,
    input  logic [15:0] vram_row_base,
    input  logic [15:0] row_offset,
    input  logic        row_en,
    output logic [15:0] row_scr,
    input  logic [7:0]  tile_addr,
    output logic [15:0] tile_data,
    input  logic        br_obj,
    output logic        bg_obj,
    input  logic [16:0] vram_obj_addr,
    input  logic        br_pal,
    output logic        bg_pal,
    input  logic [16:0] vram_pal_addr,
    output logic [16:0] vram_addr,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output logic        vram_clr,
    output logic        vram_cs,
    output logic        br,
    input  logic        bg
);

    logic        line_start;
    logic        scroll_go;
    logic [15:0] vline;
    logic        wr_en;
    logic [7:0]  wr_slot;
    logic [15:0] wr_data;
    logic [2:0]  swap_mask;

    vram_req_if line_bus ();
    vram_req_if scroll_bus ();

    line_dma #(
        .LINE_TICKS(LINE_TICKS)
    ) line_dma_i (
        .clk           (clk),
        .rst           (rst),
        .pxl_cen       (pxl_cen),
        .hb            (hb),
        .flip          (flip),
        .vrender1      (vrender1),
        .row_en        (row_en),
        .vram_row_base (vram_row_base),
        .row_offset    (row_offset),
        .hpos2         (hpos2),
        .br_obj        (br_obj),
        .br_pal        (br_pal),
        .vram_obj_addr (vram_obj_addr),
        .line_start    (line_start),
        .scroll_go     (scroll_go),
        .vline         (vline),
        .row_scr       (row_scr),
        .bg_obj        (bg_obj),
        .bus           (line_bus.requester)
    );

    scroll_fetch scroll_fetch_i (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .line_start (line_start),
        .scroll_go  (scroll_go),
        .vline      (vline),
        .hpos1      (hpos1),
        .hpos2      (hpos2),
        .hpos3      (hpos3),
        .vpos1      (vpos1),
        .vpos2      (vpos2),
        .vpos3      (vpos3),
        .vram1_base (vram1_base),
        .vram2_base (vram2_base),
        .vram3_base (vram3_base),
        .wr_en      (wr_en),
        .wr_slot    (wr_slot),
        .wr_data    (wr_data),
        .swap_mask  (swap_mask),
        .bus        (scroll_bus.requester)
    );

    tile_cache tile_cache_i (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_slot    (wr_slot),
        .wr_data    (wr_data),
        .swap_mask  (swap_mask),
        .line_start (line_start),
        .tile_addr  (tile_addr),
        .tile_data  (tile_data)
    );

    vram_arbiter vram_arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .bg            (bg),
        .br_pal        (br_pal),
        .vram_pal_addr (vram_pal_addr),
        .vram_data     (vram_data),
        .vram_ok       (vram_ok),
        .vram_addr     (vram_addr),
        .vram_cs       (vram_cs),
        .vram_clr      (vram_clr),
        .br            (br),
        .bg_pal        (bg_pal),
        .line_bus      (line_bus.arbiter),
        .scroll_bus    (scroll_bus.arbiter)
    );

endmodule

`default_nettype wire

//--- hw/vram_arbiter.sv
`default_nettype none

module vram_arbiter (
    input  logic        clk,
    input  logic        rst,
    input  logic        bg,
    input  logic        br_pal,
    input  logic [16:0] vram_pal_addr,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output logic [16:0] vram_addr,
    output logic        vram_cs,
    output logic        vram_clr,
    output logic        br,
    output logic        bg_pal,
    vram_req_if.arbiter line_bus,
    vram_req_if.arbiter scroll_bus
);

    localparam logic [1:0] M_NONE = 2'd0;
    localparam logic [1:0] M_LINE = 2'd1;
    localparam logic [1:0] M_PAL  = 2'd2;
    localparam logic [1:0] M_SCR  = 2'd3;

    logic [1:0] master;
    logic [1:0] next_master;
    logic       holder_req;

    always_comb begin
        case (master)
            M_LINE:  holder_req = line_bus.req;
            M_PAL:   holder_req = br_pal;
            M_SCR:   holder_req = scroll_bus.req;
            default: holder_req = 1'b0;
        endcase
        // Holder keeps the bus until its request falls
        if (holder_req) begin
            next_master = master;
        end else if (line_bus.req) begin
            next_master = M_LINE;
        end else if (br_pal) begin
            next_master = M_PAL;
        end else if (scroll_bus.req) begin
            next_master = M_SCR;
        end else begin
            next_master = M_NONE;
        end
    end

    always_comb begin
        case (master)
            M_PAL:   vram_addr = vram_pal_addr;
            M_SCR:   vram_addr = scroll_bus.addr;
            default: vram_addr = line_bus.addr;
        endcase
    end

    assign vram_cs        = br;
    assign bg_pal         = master == M_PAL && bg;
    assign line_bus.gnt   = master == M_LINE && bg;
    assign scroll_bus.gnt = master == M_SCR && bg;
    assign line_bus.ok    = master == M_LINE && vram_ok;
    assign scroll_bus.ok  = master == M_SCR && vram_ok;
    assign line_bus.data   = vram_data;
    assign scroll_bus.data = vram_data;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            master   <= M_NONE;
            br       <= 1'b0;
            vram_clr <= 1'b0;
        end else begin
            master   <= next_master;
            br       <= line_bus.req || br_pal || scroll_bus.req;
            // Drop stale read data on every change of master
            vram_clr <= next_master != master && next_master != M_NONE;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({line_bus.gnt, scroll_bus.gnt, bg_pal}));

endmodule

`default_nettype wire

//--- hw/vram_req_if.sv
`default_nettype none

interface vram_req_if;

    logic        req;
    logic        gnt;
    logic [16:0] addr;
    logic [15:0] data;
    logic        ok;

    // req stays high for a whole burst, addr moves only under gnt
    modport requester (
        output req,
        output addr,
        input  gnt,
        input  data,
        input  ok
    );

    modport arbiter (
        input  req,
        input  addr,
        output gnt,
        output data,
        output ok
    );

endinterface

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_video_dma.sv
`default_nettype none

module tb_video_dma;

    localparam int NUM_LINES  = 40;
    localparam int LINE_TICKS = 16;
    // Every word of the three layers plus the line window, with room for waits and stalls
    localparam int LINE_MAX   = (100 + 98 + 30 + LINE_TICKS) * 32;
    localparam logic [31:0] SEED = 32'hd0b2_39d9;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        hb;
    logic [8:0]  vrender1;
    logic        flip;
    logic [15:0] hpos_r [3];
    logic [15:0] vpos_r [3];
    logic [15:0] base_r [3];
    logic [15:0] vram_row_base;
    logic [15:0] row_offset;
    logic        row_en;
    logic [15:0] row_scr;
    logic [7:0]  tile_addr;
    logic [15:0] tile_data;
    logic        br_obj;
    logic        bg_obj;
    logic [16:0] vram_obj_addr;
    logic        br_pal;
    logic        bg_pal;
    logic [16:0] vram_pal_addr;
    logic [16:0] vram_addr;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic        vram_clr;
    logic        vram_cs;
    logic        br;
    logic        bg;

    // Stimulus and model state
    logic [31:0] lfsr;
    logic        pal_line;
    logic        stall_line;
    int          cen_period;
    int          line_cyc;
    int          pal_left;
    int          quiet;
    logic        busy_seen;
    logic        obj_seen;
    logic        have_prev;
    logic [15:0] exp_row_prev;
    logic [16:0] cur_addr;
    int          wait_left;
    logic [7:0]  rd_prev_addr;
    logic        rd_prev_on;
    logic [15:0] shown [256];
    bit          shown_ok [256];

    tb_clock #(.PERIOD(20), .RESET_CYCLES(2)) clock_i (.clk(clk), .rst(rst));

    video_dma #(
        .LINE_TICKS(LINE_TICKS)
    ) dut_i (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hb(hb), .vrender1(vrender1), .flip(flip),
        .vram1_base(base_r[0]), .hpos1(hpos_r[0]), .vpos1(vpos_r[0]),
        .vram2_base(base_r[1]), .hpos2(hpos_r[1]), .vpos2(vpos_r[1]),
        .vram3_base(base_r[2]), .hpos3(hpos_r[2]), .vpos3(vpos_r[2]),
        .vram_row_base(vram_row_base), .row_offset(row_offset), .row_en(row_en),
        .row_scr(row_scr), .tile_addr(tile_addr), .tile_data(tile_data),
        .br_obj(br_obj), .bg_obj(bg_obj), .vram_obj_addr(vram_obj_addr),
        .br_pal(br_pal), .bg_pal(bg_pal), .vram_pal_addr(vram_pal_addr),
        .vram_addr(vram_addr), .vram_data(vram_data), .vram_ok(vram_ok),
        .vram_clr(vram_clr), .vram_cs(vram_cs), .br(br), .bg(bg)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [15:0] vram_word(input logic [16:0] addr);
        return addr[15:0] ^ 16'h5a3c;
    endfunction

    // Next line number, mirrored when the screen is flipped
    function automatic logic [15:0] next_vline();
        logic [8:0] n;
        n = vrender1 + 9'd1;
        return {7'd0, flip ? n ^ 9'h0ff : n};
    endfunction

    function automatic logic [10:0] tile_mask(input int l);
        return 11'((1 << (l + 3)) - 1);
    endfunction

    function automatic logic new_tile_row(input int l);
        logic [10:0] vscr;
        vscr = vpos_r[l][10:0] + next_vline();
        return (vscr & tile_mask(l)) == 11'd0;
    endfunction

    // Tile-map word address of word i of layer l on the next line
    function automatic logic [16:0] map_addr(input int l, input int i);
        int          s;
        logic [10:0] vscr;
        logic [10:0] hn;
        logic [11:0] row;
        logic [11:0] col;
        logic [11:0] scan;
        s    = l + 3;
        vscr = vpos_r[l][10:0] + next_vline();
        hn   = vdma_pkg::HSTART[l] + (hpos_r[l][10:0] & ~tile_mask(l)) + (i / 2) * (1 << s);
        row  = (vscr >> s) & 12'h03f;
        col  = (hn >> s) & 12'h03f;
        // Tile column in the middle, tile row split around it
        scan = ((row >> (8 - s)) << (14 - s)) | (col << (8 - s)) | (row & ((1 << (8 - s)) - 1));
        return {base_r[l][9:1], 8'd0} + {4'd0, scan, 1'(i % 2)};
    endfunction

    function automatic logic [15:0] expected_row_scr();
        logic [15:0] vl;
        logic [9:0]  idx;
        logic [16:0] addr;
        vl   = next_vline();
        idx  = row_offset[9:0] + vl[9:0];
        addr = {vram_row_base[9:1], 8'd0} + {7'd0, idx};
        return {12'd0, hpos_r[1][3:0]} + (row_en ? vram_word(addr) : 16'd0);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Layers fetched on the last line become readable after this line_start
    task automatic commit_fetch();
        int l;
        int i;
        int first;
        if (have_prev && !pal_line) begin
            for (l = 0; l < 3; l++) begin
                if (new_tile_row(l)) begin
                    first = vdma_pkg::SLOT_FIRST[l];
                    for (i = 0; i <= vdma_pkg::SLOT_LAST[l] - first; i++) begin
                        shown[first + i]    = vram_word(map_addr(l, i));
                        shown_ok[first + i] = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic pick_line();
        int l;
        vrender1      = rand_bits(9);
        flip          = rand_bits(1);
        row_en        = rand_bits(1);
        vram_row_base = rand_bits(16);
        row_offset    = rand_bits(16);
        br_obj        = rand_bits(1);
        pal_line      = rand_bits(2) == 0;
        pal_left      = pal_line ? 2 + rand_bits(2) : 0;
        stall_line    = rand_bits(1);
        cen_period    = 2 + rand_bits(2) % 3;
        for (l = 0; l < 3; l++) begin
            hpos_r[l] = rand_bits(16);
            vpos_r[l] = rand_bits(16);
            base_r[l] = rand_bits(16);
            // Most lines start a new tile row so the cache sees traffic
            if (rand_bits(2) != 0) begin
                vpos_r[l] = vpos_r[l] - ((vpos_r[l] + next_vline()) & 16'(tile_mask(l)));
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
        if (line_cyc == 0) begin
            pick_line();
        end
        hb = line_cyc < 4;
        // Palette request opens one cycle after the line engine asks
        if (line_cyc == 1) begin
            br_pal = pal_line;
        end else if (pal_left == 0) begin
            br_pal = 1'b0;
        end
        pxl_cen       = line_cyc % cen_period == 0;
        bg            = !(stall_line && rand_bits(2) == 0);
        vram_obj_addr = rand_bits(17);
        vram_pal_addr = rand_bits(17);
        tile_addr     = rand_bits(8);
        #1;
        // VRAM model answers 0 to 3 cycles after the address settles
        if (!vram_cs || vram_addr !== cur_addr) begin
            cur_addr  = vram_addr;
            wait_left = rand_bits(2);
        end else if (wait_left != 0) begin
            wait_left = wait_left - 1;
        end
        vram_ok   = vram_cs && !vram_clr && wait_left == 0;
        vram_data = vram_word(vram_addr);
        @(negedge clk);
        if (rd_prev_on && shown_ok[rd_prev_addr]) begin
            check_value("tile_data", tile_data, shown[rd_prev_addr]);
        end
        rd_prev_on   = line_cyc >= 2;
        rd_prev_addr = tile_addr;
        if (bg_obj) begin
            check_value("br_obj", br_obj, 1'b1);
            check_value("br_pal", br_pal, 1'b0);
            check_value("vram_addr", vram_addr, vram_obj_addr);
            obj_seen = 1'b1;
        end
        if (bg_pal) begin
            check_value("vram_addr", vram_addr, vram_pal_addr);
            if (pal_left != 0) begin
                pal_left = pal_left - 1;
            end
        end
        if (vram_cs) begin
            busy_seen = 1'b1;
            quiet     = 0;
        end else if (!br_pal) begin
            quiet = quiet + 1;
        end
        line_cyc = line_cyc + 1;
    endtask

    // One video line, ended once the bus has stayed quiet
    task automatic run_line();
        commit_fetch();
        line_cyc   = 0;
        quiet      = 0;
        busy_seen  = 1'b0;
        obj_seen   = 1'b0;
        rd_prev_on = 1'b0;
        while (!(busy_seen && quiet >= 8)) begin
            step_cycle();
        end
        check_value("bg_obj", obj_seen, br_obj && !pal_line);
        check_value("row_scr", row_scr, exp_row_prev);
        exp_row_prev = expected_row_scr();
        have_prev    = 1'b1;
    endtask

    initial begin
        #(NUM_LINES * LINE_MAX * 20);
        $display("Timeout: the DUT did not finish its lines in time");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        lfsr          = SEED;
        pxl_cen       = 1'b0;
        hb            = 1'b0;
        vrender1      = 9'd0;
        flip          = 1'b0;
        vram_row_base = 16'd0;
        row_offset    = 16'd0;
        row_en        = 1'b0;
        tile_addr     = 8'd0;
        br_obj        = 1'b0;
        vram_obj_addr = 17'd0;
        br_pal        = 1'b0;
        vram_pal_addr = 17'd0;
        vram_data     = 16'd0;
        vram_ok       = 1'b0;
        bg            = 1'b1;
        for (int l = 0; l < 3; l++) begin
            hpos_r[l] = 16'd0;
            vpos_r[l] = 16'd0;
            base_r[l] = 16'd0;
        end
        pal_line     = 1'b0;
        pal_left     = 0;
        have_prev    = 1'b0;
        exp_row_prev = 16'd0;
        cur_addr     = 17'd0;
        wait_left    = 0;
        wait (rst == 1'b0);
        @(negedge clk);
        check_value("br", br, 1'b0);
        check_value("vram_cs", vram_cs, 1'b0);
        check_value("vram_clr", vram_clr, 1'b0);
        check_value("bg_obj", bg_obj, 1'b0);
        check_value("bg_pal", bg_pal, 1'b0);
        repeat (NUM_LINES) begin
            run_line();
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
